//--- common/board_pkg.sv
// **************************************************
// board package
// constants for the board wrapper around the MCU
// **************************************************

`default_nettype none

package board_pkg;

  // heartbeat counter width
  // the MSB toggles every 2**(HEARTBEAT_WIDTH-1) clk_gen cycles
  localparam int unsigned HEARTBEAT_WIDTH = 6;

  // flops in the reset release synchronizer
  localparam int unsigned RST_SYNC_STAGES = 2;

endpackage : board_pkg

`default_nettype wire

//--- common/mcu_pkg.sv
// **************************************************
// mcu package
// instruction format, opcodes, core states and widths
// **************************************************

`default_nettype none

package mcu_pkg;

  localparam int unsigned INSTR_WIDTH = 16;
  localparam int unsigned OPC_WIDTH   = 4;
  localparam int unsigned IMM_WIDTH   = 12;
  localparam int unsigned DATA_WIDTH  = 32;
  localparam int unsigned GPIO_WIDTH  = 20;
  localparam int unsigned PC_WIDTH    = 5;

  // program entry points, picked by boot select
  localparam logic [PC_WIDTH-1:0] BOOT_ADDR_0 = 5'd0;
  localparam logic [PC_WIDTH-1:0] BOOT_ADDR_1 = 5'd16;

  // instruction is {opcode, imm}
  typedef enum logic [OPC_WIDTH-1:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_SUBI = 4'h2,
    OP_XORI = 4'h3,
    OP_IN   = 4'h4,
    OP_OUT  = 4'h5,
    OP_BNZ  = 4'h6,
    OP_EXIT = 4'h7
  } opcode_e;

  typedef enum logic {
    ST_RUN  = 1'b0,
    ST_HALT = 1'b1
  } core_state_e;

endpackage : mcu_pkg

`default_nettype wire

//--- verilog/clk_divider.sv
// **************************************************
// clock divider
// toggle flop making clk_gen at half the board clock
// **************************************************

`default_nettype none

module clk_divider (
  input  wire  clk_i,
  input  wire  rst_ni,
  output logic clk_o
);

  logic div_q;

  // held low while the board reset is active
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q <= 1'b0;
    end else begin
      div_q <= ~div_q;
    end
  end

  assign clk_o = div_q;

endmodule : clk_divider

`default_nettype wire

//--- mini_system/program_rom.sv
// **************************************************
// program ROM
// both boot programs as a combinational table
// **************************************************

`default_nettype none

module program_rom
  import mcu_pkg::*;
(
  input  wire  [PC_WIDTH-1:0]    pc_i,
  output logic [INSTR_WIDTH-1:0] instr_o
);

  always_comb begin
    case (pc_i)
      // program 0, count down 3..1 then report 42
      5'd0:  instr_o = {OP_LDI, IMM_WIDTH'(3)};
      5'd1:  instr_o = {OP_OUT, IMM_WIDTH'(0)};
      5'd2:  instr_o = {OP_SUBI, IMM_WIDTH'(1)};
      5'd3:  instr_o = {OP_BNZ, IMM_WIDTH'(1)};
      5'd4:  instr_o = {OP_LDI, IMM_WIDTH'(42)};
      5'd5:  instr_o = {OP_OUT, IMM_WIDTH'(0)};
      5'd6:  instr_o = {OP_EXIT, IMM_WIDTH'(0)};

      // program 1, echo the input inverted in its low byte
      5'd16: instr_o = {OP_IN, IMM_WIDTH'(0)};
      5'd17: instr_o = {OP_XORI, IMM_WIDTH'(255)};
      5'd18: instr_o = {OP_OUT, IMM_WIDTH'(0)};
      5'd19: instr_o = {OP_EXIT, IMM_WIDTH'(0)};

      default: instr_o = {OP_NOP, IMM_WIDTH'(0)};
    endcase
  end

endmodule : program_rom

`default_nettype wire

//--- mini_system/seq_core.sv
// **************************************************
// sequencer core
// accumulator machine, one instruction per cycle
// **************************************************

`default_nettype none

module seq_core
  import mcu_pkg::*;
(
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    boot_select_i,
  input  wire  [INSTR_WIDTH-1:0] instr_i,
  input  wire  [GPIO_WIDTH-1:0]  gpio_i,
  output logic [PC_WIDTH-1:0]    pc_o,
  output logic [DATA_WIDTH-1:0]  acc_o,
  output logic                   gpio_we_o,
  output logic                   exit_we_o
);

  core_state_e           state_q;
  core_state_e           state_d;
  logic                  started_q;
  logic [PC_WIDTH-1:0]   pc_q;
  logic [PC_WIDTH-1:0]   pc_cur;
  logic [PC_WIDTH-1:0]   pc_d;
  logic [DATA_WIDTH-1:0] acc_q;
  logic [DATA_WIDTH-1:0] acc_d;
  opcode_e               opcode;
  logic [IMM_WIDTH-1:0]  imm;
  logic [DATA_WIDTH-1:0] imm_ext;

  assign opcode  = opcode_e'(instr_i[INSTR_WIDTH-1 -: OPC_WIDTH]);
  assign imm     = instr_i[IMM_WIDTH-1:0];
  assign imm_ext = DATA_WIDTH'(imm);

  // first cycle after reset fetches from the boot address directly
  assign pc_cur = started_q ? pc_q : (boot_select_i ? BOOT_ADDR_1 : BOOT_ADDR_0);
  assign pc_o   = pc_cur;

  // peripherals capture the accumulator on a strobe
  assign acc_o = acc_q;

  always_comb begin
    state_d   = state_q;
    pc_d      = pc_cur;
    acc_d     = acc_q;
    gpio_we_o = 1'b0;
    exit_we_o = 1'b0;
    if (state_q == ST_RUN) begin
      pc_d = pc_cur + 1'b1;
      case (opcode)
        OP_LDI:  acc_d = imm_ext;
        OP_SUBI: acc_d = acc_q - imm_ext;
        OP_XORI: acc_d = acc_q ^ imm_ext;
        OP_IN:   acc_d = DATA_WIDTH'(gpio_i);
        OP_OUT:  gpio_we_o = 1'b1;
        OP_BNZ: begin
          if (acc_q != '0) begin
            pc_d = imm[PC_WIDTH-1:0];
          end
        end
        OP_EXIT: begin
          exit_we_o = 1'b1;
          state_d   = ST_HALT;
          pc_d      = pc_cur;
        end
        // nop and unused encodings
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_RUN;
      started_q <= 1'b0;
      pc_q      <= '0;
      acc_q     <= '0;
    end else begin
      state_q   <= state_d;
      started_q <= 1'b1;
      pc_q      <= pc_d;
      acc_q     <= acc_d;
    end
  end

endmodule : seq_core

`default_nettype wire

//--- mini_system/periph_regs.sv
// **************************************************
// peripheral registers
// GPIO output and exit value/valid
// **************************************************

`default_nettype none

module periph_regs
  import mcu_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire  [DATA_WIDTH-1:0] acc_i,
  input  wire                   gpio_we_i,
  input  wire                   exit_we_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [DATA_WIDTH-1:0] exit_value_o,
  output logic                  exit_valid_o
);

  logic [GPIO_WIDTH-1:0] gpio_q;
  logic [DATA_WIDTH-1:0] exit_value_q;
  logic                  exit_valid_q;

  // gpio output register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gpio_q <= '0;
    end else if (gpio_we_i) begin
      gpio_q <= acc_i[GPIO_WIDTH-1:0];
    end
  end

  // exit value, valid is sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
    end else if (exit_we_i) begin
      exit_value_q <= acc_i;
      exit_valid_q <= 1'b1;
    end
  end

  assign gpio_o       = gpio_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule : periph_regs

`default_nettype wire

//--- mini_system/mini_system.sv
// **************************************************
// mini system
// sequencer core, program ROM and peripheral registers
// **************************************************

`default_nettype none

module mini_system
  import mcu_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire                   boot_select_i,
  input  wire  [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic                  exit_value_o,
  output logic                  exit_valid_o
);

  logic [PC_WIDTH-1:0]    pc;
  logic [INSTR_WIDTH-1:0] instr;
  logic [DATA_WIDTH-1:0]  acc;
  logic                   gpio_we;
  logic                   exit_we;
  logic [DATA_WIDTH-1:0]  exit_value;

  seq_core seq_core_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .boot_select_i(boot_select_i),
    .instr_i      (instr),
    .gpio_i       (gpio_i),
    .pc_o         (pc),
    .acc_o        (acc),
    .gpio_we_o    (gpio_we),
    .exit_we_o    (exit_we)
  );

  program_rom program_rom_i (
    .pc_i   (pc),
    .instr_o(instr)
  );

  periph_regs periph_regs_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_i       (acc),
    .gpio_we_i   (gpio_we),
    .exit_we_i   (exit_we),
    .gpio_o      (gpio_o),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid_o)
  );

  // only the LSB reaches a pin
  assign exit_value_o = exit_value[0];

endmodule : mini_system

`default_nettype wire

//--- board_wrapper/board_wrapper.sv
// **************************************************
// board wrapper
// reset and clock generation, heartbeat LED and MCU
// **************************************************

`default_nettype none

module board_wrapper
  import board_pkg::*;
  import mcu_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   boot_select_i,
  input  wire  [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic                  exit_value_o,
  output logic                  exit_valid_o,
  output logic                  rst_led_o,
  output logic                  clk_led_o,
  output logic                  clk_out_o
);

  logic                       rst_n;
  logic                       clk_gen;
  logic [RST_SYNC_STAGES-1:0] rst_sync_q;
  logic                       sys_rst_n;
  logic [HEARTBEAT_WIDTH-1:0] clk_count_q;

  // board reset is active high
  assign rst_n = ~rst_i;

  clk_divider clk_divider_i (
    .clk_i (clk_i),
    .rst_ni(rst_n),
    .clk_o (clk_gen)
  );

  // async assert, release on clk_gen
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign sys_rst_n = rst_sync_q[RST_SYNC_STAGES-1];

  // free running heartbeat
  always_ff @(posedge clk_gen or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  // visibility signals
  assign clk_led_o = clk_count_q[HEARTBEAT_WIDTH-1];
  assign rst_led_o = sys_rst_n;
  assign clk_out_o = clk_gen;

  mini_system mini_system_i (
    .clk_i        (clk_gen),
    .rst_ni       (sys_rst_n),
    .boot_select_i(boot_select_i),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule : board_wrapper

`default_nettype wire

//--- verification/tb_clock.sv
// **************************************************
// testbench clock
// free running board clock, period 40
// **************************************************

`default_nettype none

module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // half period
  always #20 clk_o = ~clk_o;

endmodule : tb_clock

`default_nettype wire

//--- verification/tb_board_wrapper.sv
// **************************************************
// board wrapper testbench
// runs both boot programs and checks reset, clocks, LEDs
// **************************************************

`default_nettype none

module tb_board_wrapper
  import mcu_pkg::*;
();

  logic                  clk_i;
  logic                  rst_i;
  logic                  boot_select_i;
  logic [GPIO_WIDTH-1:0] gpio_i;
  logic [GPIO_WIDTH-1:0] gpio_o;
  logic                  exit_value_o;
  logic                  exit_valid_o;
  logic                  rst_led_o;
  logic                  clk_led_o;
  logic                  clk_out_o;

  int                    check_count = 0;
  int                    error_count = 0;
  int                    timeout_count = 0;
  logic [31:0]           seed;
  logic [GPIO_WIDTH-1:0] gval;

  // edge monitor state
  logic                  clk_out_prev = 1'b0;
  logic                  rst_led_prev = 1'b0;
  logic                  led_prev = 1'b0;
  int                    low_edges = 0;
  int                    rise_count = 0;

  tb_clock tb_clock_i (
    .clk_o(clk_i)
  );

  board_wrapper board_wrapper_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .boot_select_i(boot_select_i),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o),
    .rst_led_o    (rst_led_o),
    .clk_led_o    (clk_led_o),
    .clk_out_o    (clk_out_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    timeout_count++;
    $display("timeout while waiting for %s at t=%0t", what, $time);
  endtask

  // exit_valid may never drop while the system is out of reset
  valid_sticky: assert property (@(posedge clk_out_o) disable iff (!rst_led_o)
    exit_valid_o |=> exit_valid_o)
  else begin
    error_count++;
    $display("[FAIL] t=%0t exit_valid_o expected 0x1 got 0x0", $time);
  end

  // sampled before the edge, so all DUT outputs are settled
  always @(posedge clk_i) begin : edge_monitor
    logic rise_now;
    rise_now = clk_out_o && !clk_out_prev;
    if (!rst_i) begin
      if (low_edges > 0) begin
        check_value("clk_out_o", !clk_out_prev, clk_out_o);
      end
      low_edges++;
    end else begin
      low_edges = 0;
    end
    // heartbeat counts from the clk_gen edge that released reset
    if (rst_led_o && rst_led_prev) begin
      if (clk_led_o !== led_prev) begin
        check_value("clk_led_o rises per toggle", 32, rise_count + rise_now);
        rise_count = 0;
      end else begin
        rise_count += rise_now;
      end
    end else begin
      rise_count = 0;
    end
    clk_out_prev = clk_out_o;
    rst_led_prev = rst_led_o;
    led_prev     = clk_led_o;
  end

  task automatic apply_reset(input logic bsel, input logic [GPIO_WIDTH-1:0] value);
    int   rises;
    int   waited;
    logic clk_out_last;
    @(negedge clk_i);
    rst_i         = 1'b1;
    boot_select_i = bsel;
    gpio_i        = value;
    repeat (16) begin
      @(negedge clk_i);
      check_value("gpio_o", 0, gpio_o);
      check_value("exit_valid_o", 0, exit_valid_o);
      check_value("exit_value_o", 0, exit_value_o);
      check_value("clk_led_o", 0, clk_led_o);
      check_value("rst_led_o", 0, rst_led_o);
    end
    rst_i        = 1'b0;
    rises        = 0;
    waited       = 0;
    clk_out_last = clk_out_o;
    // release lands on the second clk_gen rising edge
    while (rises < 2 && waited < 20) begin
      @(negedge clk_i);
      waited++;
      if (clk_out_o && !clk_out_last) begin
        rises++;
      end
      clk_out_last = clk_out_o;
      check_value("rst_led_o", (rises >= 2), rst_led_o);
    end
    if (rises < 2) begin
      report_timeout("clk_out_o rising edges after reset release");
    end
  endtask

  task automatic wait_exit_valid(input string what);
    int waited;
    waited = 0;
    while (!exit_valid_o && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (!exit_valid_o) begin
      report_timeout(what);
    end
  endtask

  // a halted core must not wrap around the ROM and rerun a program
  task automatic hold_after_exit(input logic [GPIO_WIDTH-1:0] gpio_exp);
    repeat (80) begin
      @(negedge clk_i);
      check_value("gpio_o", gpio_exp, gpio_o);
      check_value("exit_valid_o", 1, exit_valid_o);
    end
  endtask

  task automatic run_program0();
    logic [GPIO_WIDTH-1:0] seen[$];
    logic [GPIO_WIDTH-1:0] expected[$];
    logic [GPIO_WIDTH-1:0] last;
    int                    waited;
    // count down from 3, then 42
    expected = '{20'd3, 20'd2, 20'd1, 20'd42};
    last     = gpio_o;
    waited   = 0;
    while (!exit_valid_o && waited < 200) begin
      @(negedge clk_i);
      waited++;
      if (gpio_o !== last) begin
        seen.push_back(gpio_o);
        last = gpio_o;
      end
    end
    if (!exit_valid_o) begin
      report_timeout("exit_valid_o after boot program 0");
    end
    check_value("gpio_o change count", expected.size(), seen.size());
    foreach (expected[i]) begin
      if (i < seen.size()) begin
        check_value("gpio_o", expected[i], seen[i]);
      end
    end
    check_value("exit_value_o", expected[3][0], exit_value_o);
    hold_after_exit(expected[3]);
  endtask

  task automatic run_program1(input logic [GPIO_WIDTH-1:0] value);
    wait_exit_valid("exit_valid_o after boot program 1");
    check_value("gpio_o", value ^ 20'h000ff, gpio_o);
    check_value("exit_value_o", !value[0], exit_value_o);
    hold_after_exit(value ^ 20'h000ff);
  endtask

  task automatic watch_heartbeat(input int toggles);
    int   seen_toggles;
    int   waited;
    logic led_last;
    seen_toggles = 0;
    waited       = 0;
    led_last     = clk_led_o;
    while (seen_toggles < toggles && waited < toggles * 64 + 80) begin
      @(negedge clk_i);
      waited++;
      if (clk_led_o !== led_last) begin
        seen_toggles++;
      end
      led_last = clk_led_o;
    end
    if (seen_toggles < toggles) begin
      report_timeout("clk_led_o toggles");
    end
  endtask

  initial begin
    rst_i         = 1'b1;
    boot_select_i = 1'b0;
    gpio_i        = '0;
    seed          = 32'h99d0;

    apply_reset(1'b0, '0);
    run_program0();
    watch_heartbeat(3);

    // reset after exit, program 0 starts over
    apply_reset(1'b0, '0);
    run_program0();

    repeat (4) begin
      seed = xorshift32(seed);
      gval = seed[GPIO_WIDTH-1:0];
      apply_reset(1'b1, gval);
      run_program1(gval);
    end
    watch_heartbeat(2);

    $display("checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_board_wrapper

`default_nettype wire

//--- list.f
common/board_pkg.sv
common/mcu_pkg.sv
verilog/clk_divider.sv
mini_system/program_rom.sv
mini_system/seq_core.sv
mini_system/periph_regs.sv
mini_system/mini_system.sv
board_wrapper/board_wrapper.sv
verification/tb_clock.sv
verification/tb_board_wrapper.sv

//--- Bender.yml
package:
  name: board_wrapper

sources:
  - common/board_pkg.sv
  - common/mcu_pkg.sv
  - verilog/clk_divider.sv
  - mini_system/program_rom.sv
  - mini_system/seq_core.sv
  - mini_system/periph_regs.sv
  - mini_system/mini_system.sv
  - board_wrapper/board_wrapper.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tb_board_wrapper.sv
